/* Bender.yml */
package:
  name: bfly4

sources:
  - common/bfly4_pkg.sv
  - logic/cplx_mul.sv
  - butterfly/bfly4_ctrl.sv
  - butterfly/bfly4_addr_gen.sv
  - butterfly/bfly4_datapath.sv
  - butterfly/bfly4_top.sv
  - target: simulation
    files:
      - verif/bfly4_mem_model.sv
      - verif/tb_bfly4.sv

/* butterfly/bfly4_addr_gen.sv */
// Output pointers and twiddle address accumulators
// Bus address and strobe selection

module bfly4_addr_gen (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  bfly4_pkg::bfly4_state_t      state_i,
    input  logic                         ack_i,
    input  logic [bfly4_pkg::CNT_W-1:0]  m_i,
    input  logic [bfly4_pkg::CNT_W-1:0]  fstride_i,
    input  logic [bfly4_pkg::ADDR_W-1:0] foutadr_i,
    output logic [bfly4_pkg::ADDR_W-1:0] adr_o,
    output logic                         rd_o,
    output logic                         wr_o,
    output logic [bfly4_pkg::TW_AW-1:0]  tw_adr_o,
    output logic                         tw_rd_o
);
    import bfly4_pkg::*;

    logic [ADDR_W-1:0] m_step;
    logic [ADDR_W-1:0] ptr_q [4];
    logic [1:0]        ptr_sel;
    logic [TW_AW-1:0]  tw_step;
    logic [TW_AW-1:0]  tw1_q;
    logic [TW_AW-1:0]  tw2_q;
    logic [TW_AW-1:0]  tw3_q;

    assign m_step  = ADDR_W'(m_i) * SAMPLE_STEP;
    assign tw_step = TW_AW'(fstride_i);

    // Output k of the current group
    always_comb begin
        case (state_i)
            LOAD1, SAVE1: ptr_sel = 2'd1;
            LOAD2, SAVE2: ptr_sel = 2'd2;
            LOAD3, SAVE3: ptr_sel = 2'd3;
            default:      ptr_sel = 2'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < 4; k++) begin
                ptr_q[k] <= '0;
            end
        end else if (state_i == INIT) begin
            ptr_q[0] <= foutadr_i;
            ptr_q[1] <= foutadr_i + m_step;
            ptr_q[2] <= foutadr_i + (m_step << 1);
            ptr_q[3] <= foutadr_i + (m_step << 1) + m_step;
        end else if (wr_o && ack_i) begin
            ptr_q[ptr_sel] <= ptr_q[ptr_sel] + SAMPLE_STEP;
        end
    end

    assign rd_o  = state_i inside {LOAD2, LOAD3, LOAD1, LOAD0};
    assign wr_o  = state_i inside {SAVE2, SAVE0, SAVE3, SAVE1};
    assign adr_o = (rd_o || wr_o) ? ptr_q[ptr_sel] : '0;

    //////////////////////////////
    // Twiddles j*f, 2j*f and 3j*f

    always_ff @(posedge clk_i) begin
        if (rst_i || state_i == INIT) begin
            tw1_q <= '0;
            tw2_q <= '0;
            tw3_q <= '0;
        end else if (ack_i) begin
            case (state_i)
                SAVE1: begin
                    tw3_q <= tw3_q + tw_step;
                end
                SAVE0: begin
                    tw2_q <= tw2_q + tw_step;
                    tw3_q <= tw3_q + tw_step;
                end
                SAVE3: begin
                    tw1_q <= tw1_q + tw_step;
                    tw2_q <= tw2_q + tw_step;
                    tw3_q <= tw3_q + tw_step;
                end
                default: begin
                end
            endcase
        end
    end

    // ROM read issued on the ack, so the twiddle lines up with the next operand
    always_comb begin
        case (state_i)
            LOAD3:   tw_adr_o = tw2_q;
            LOAD1:   tw_adr_o = tw3_q;
            LOAD0:   tw_adr_o = tw1_q;
            default: tw_adr_o = '0;
        endcase
    end

    assign tw_rd_o = ack_i && (state_i inside {LOAD3, LOAD1, LOAD0});

    rd_wr_excl_a: assert property (@(posedge clk_i) disable iff (rst_i) !(rd_o && wr_o));

    // A waiting access keeps its strobe and address
    adr_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (rd_o || wr_o) && !ack_i |=> $stable(adr_o) && $stable(rd_o) && $stable(wr_o));

endmodule

/* butterfly/bfly4_ctrl.sv */
// Butterfly sequencer FSM
// Group counter and finish pulse

module bfly4_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  logic                        ack_i,
    input  logic [bfly4_pkg::CNT_W-1:0] m_i,
    output bfly4_pkg::bfly4_state_t     state_o,
    output logic                        finish_o
);
    import bfly4_pkg::*;

    bfly4_state_t     state_q;
    bfly4_state_t     state_d;
    bfly4_state_t     next_seq;
    logic             bus_state;
    logic [CNT_W-1:0] grp_cnt_q;
    logic             last_grp;

    //////////////////////////////
    // State sequence

    always_comb begin
        next_seq = IDLE;
        case (state_q)
            IDLE:    next_seq = start_i ? INIT : IDLE;
            INIT:    next_seq = LOAD2;
            LOAD2:   next_seq = LOAD3;
            LOAD3:   next_seq = LOAD1;
            LOAD1:   next_seq = LOAD0;
            LOAD0:   next_seq = EXEC0;
            EXEC0:   next_seq = EXEC1;
            EXEC1:   next_seq = EXEC2;
            EXEC2:   next_seq = EXEC3;
            EXEC3:   next_seq = EXEC4;
            EXEC4:   next_seq = SAVE2;
            SAVE2:   next_seq = SAVE0;
            SAVE0:   next_seq = SAVE3;
            SAVE3:   next_seq = SAVE1;
            SAVE1:   next_seq = last_grp ? IDLE : LOAD2;
            default: next_seq = IDLE;
        endcase
    end

    // Bus states wait for the acknowledge
    assign bus_state = state_q inside {LOAD2, LOAD3, LOAD1, LOAD0,
                                       SAVE2, SAVE0, SAVE3, SAVE1};
    assign state_d = (bus_state && !ack_i) ? state_q : next_seq;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // Group counter

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grp_cnt_q <= '0;
        end else if (state_q == INIT) begin
            grp_cnt_q <= m_i;
        end else if (state_q == LOAD2 && ack_i) begin
            grp_cnt_q <= grp_cnt_q - 1'b1;
        end
    end

    assign last_grp = (grp_cnt_q == '0);
    assign finish_o = (state_q == SAVE1) && ack_i && last_grp;
    assign state_o  = state_q;

    state_valid_a: assert property (@(posedge clk_i) disable iff (rst_i)
        state_q inside {IDLE, INIT, LOAD2, LOAD3, LOAD1, LOAD0, EXEC0, EXEC1,
                        EXEC2, EXEC3, EXEC4, SAVE2, SAVE0, SAVE3, SAVE1});

endmodule

/* butterfly/bfly4_datapath.sv */
// Quarter scaling, working and scratch registers
// Adder, subtractor and rotation schedule of the radix-4 butterfly
// Write data selection

module bfly4_datapath (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  bfly4_pkg::bfly4_state_t             state_i,
    input  logic                                ack_i,
    input  logic                                inv_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] dat_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] dat_im_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] tw_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] tw_im_i,
    output logic signed [bfly4_pkg::WORD_W-1:0] dat_re_o,
    output logic signed [bfly4_pkg::WORD_W-1:0] dat_im_o
);
    import bfly4_pkg::*;

    logic signed [WORD_W-1:0] div4_re_q;
    logic signed [WORD_W-1:0] div4_im_q;
    // out_*_q[k] holds input k, later output k
    logic signed [WORD_W-1:0] out_re_q [4];
    logic signed [WORD_W-1:0] out_im_q [4];
    logic signed [WORD_W-1:0] scr_re_q [6];
    logic signed [WORD_W-1:0] scr_im_q [6];

    logic                     load_ack;
    logic                     mul_hold;
    logic signed [WORD_W-1:0] mul_a_re;
    logic signed [WORD_W-1:0] mul_a_im;
    logic signed [WORD_W-1:0] mul_x_re;
    logic signed [WORD_W-1:0] mul_x_im;
    logic signed [WORD_W-1:0] opa_re;
    logic signed [WORD_W-1:0] opa_im;
    logic signed [WORD_W-1:0] add_b_re;
    logic signed [WORD_W-1:0] add_b_im;
    logic signed [WORD_W-1:0] sub_b_re;
    logic signed [WORD_W-1:0] sub_b_im;
    logic signed [WORD_W-1:0] add_re;
    logic signed [WORD_W-1:0] add_im;
    logic signed [WORD_W-1:0] sub_re;
    logic signed [WORD_W-1:0] sub_im;
    logic                     rot_neg;
    logic signed [WORD_W-1:0] rot_re;
    logic signed [WORD_W-1:0] rot_im;

    assign load_ack = ack_i && (state_i inside {LOAD2, LOAD3, LOAD1, LOAD0});

    always_ff @(posedge clk_i) begin
        if (load_ack) begin
            div4_re_q <= dat_re_i >>> 2;
            div4_im_q <= dat_im_i >>> 2;
        end
    end

    //////////////////////////////
    // Twiddle products

    assign mul_hold = !ack_i && (state_i inside {LOAD1, LOAD0});
    assign mul_a_re = (state_i == LOAD1) ? out_re_q[2] :
                      (state_i == LOAD0) ? out_re_q[3] : out_re_q[1];
    assign mul_a_im = (state_i == LOAD1) ? out_im_q[2] :
                      (state_i == LOAD0) ? out_im_q[3] : out_im_q[1];

    cplx_mul u_cplx_mul (
        .clk_i  (clk_i),
        .hold_i (mul_hold),
        .a_re_i (mul_a_re),
        .a_im_i (mul_a_im),
        .b_re_i (tw_re_i),
        .b_im_i (tw_im_i),
        .x_re_o (mul_x_re),
        .x_im_o (mul_x_im)
    );

    //////////////////////////////
    // Add, subtract and rotate

    assign opa_re   = (state_i == EXEC3) ? scr_re_q[0] : out_re_q[0];
    assign opa_im   = (state_i == EXEC3) ? scr_im_q[0] : out_im_q[0];
    assign add_b_re = (state_i == EXEC1) ? scr_re_q[1] :
                      (state_i == EXEC3) ? scr_re_q[2] : scr_re_q[3];
    assign add_b_im = (state_i == EXEC1) ? scr_im_q[1] :
                      (state_i == EXEC3) ? scr_im_q[2] : scr_im_q[3];
    assign sub_b_re = (state_i == EXEC3) ? scr_re_q[2] :
                      (state_i == EXEC4) ? scr_re_q[3] : scr_re_q[1];
    assign sub_b_im = (state_i == EXEC3) ? scr_im_q[2] :
                      (state_i == EXEC4) ? scr_im_q[3] : scr_im_q[1];
    assign add_re   = opa_re + add_b_re;
    assign add_im   = opa_im + add_b_im;
    assign sub_re   = opa_re - sub_b_re;
    assign sub_im   = opa_im - sub_b_im;

    // s5 +/- (s4.im, -s4.re), X1 in EXEC4 and X3 in SAVE2
    assign rot_neg = inv_i ^ (state_i == SAVE2);
    assign rot_re  = rot_neg ? scr_re_q[5] - scr_im_q[4] : scr_re_q[5] + scr_im_q[4];
    assign rot_im  = rot_neg ? scr_im_q[5] + scr_re_q[4] : scr_im_q[5] - scr_re_q[4];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < 4; k++) begin
                out_re_q[k] <= '0;
                out_im_q[k] <= '0;
            end
        end else begin
            case (state_i)
                LOAD3: begin
                    if (ack_i) begin
                        out_re_q[2] <= div4_re_q;
                        out_im_q[2] <= div4_im_q;
                    end
                end
                LOAD1: begin
                    if (ack_i) begin
                        out_re_q[3] <= div4_re_q;
                        out_im_q[3] <= div4_im_q;
                    end
                end
                LOAD0: begin
                    if (ack_i) begin
                        out_re_q[1] <= div4_re_q;
                        out_im_q[1] <= div4_im_q;
                    end
                end
                EXEC0: begin
                    out_re_q[0] <= div4_re_q;
                    out_im_q[0] <= div4_im_q;
                end
                // f0 = a + s1
                EXEC1: begin
                    out_re_q[0] <= add_re;
                    out_im_q[0] <= add_im;
                end
                EXEC4: begin
                    out_re_q[0] <= add_re;
                    out_im_q[0] <= add_im;
                    out_re_q[1] <= rot_re;
                    out_im_q[1] <= rot_im;
                    out_re_q[2] <= sub_re;
                    out_im_q[2] <= sub_im;
                end
                SAVE2: begin
                    if (ack_i) begin
                        out_re_q[3] <= rot_re;
                        out_im_q[3] <= rot_im;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // s1, s2 and s0 leave the multiplier in EXEC0, EXEC1 and EXEC2
    always_ff @(posedge clk_i) begin
        case (state_i)
            EXEC0: begin
                scr_re_q[1] <= mul_x_re;
                scr_im_q[1] <= mul_x_im;
            end
            EXEC1: begin
                scr_re_q[2] <= mul_x_re;
                scr_im_q[2] <= mul_x_im;
                scr_re_q[5] <= sub_re;
                scr_im_q[5] <= sub_im;
            end
            EXEC2: begin
                scr_re_q[0] <= mul_x_re;
                scr_im_q[0] <= mul_x_im;
            end
            EXEC3: begin
                scr_re_q[3] <= add_re;
                scr_im_q[3] <= add_im;
                scr_re_q[4] <= sub_re;
                scr_im_q[4] <= sub_im;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (state_i)
            SAVE0: begin
                dat_re_o = out_re_q[0];
                dat_im_o = out_im_q[0];
            end
            SAVE1: begin
                dat_re_o = out_re_q[1];
                dat_im_o = out_im_q[1];
            end
            SAVE2: begin
                dat_re_o = out_re_q[2];
                dat_im_o = out_im_q[2];
            end
            SAVE3: begin
                dat_re_o = out_re_q[3];
                dat_im_o = out_im_q[3];
            end
            default: begin
                dat_re_o = '0;
                dat_im_o = '0;
            end
        endcase
    end

endmodule

/* butterfly/bfly4_top.sv */
// Radix-4 butterfly engine top level
// Sequencer, address generator and datapath

module bfly4_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // Command
    input  logic                                start_i,
    input  logic [bfly4_pkg::CNT_W-1:0]         m_i,
    input  logic [bfly4_pkg::CNT_W-1:0]         fstride_i,
    input  logic [bfly4_pkg::ADDR_W-1:0]        foutadr_i,
    input  logic                                inv_i,
    output logic                                finish_o,
    // Data memory bus
    output logic [bfly4_pkg::ADDR_W-1:0]        adr_o,
    output logic                                rd_o,
    output logic                                wr_o,
    output logic signed [bfly4_pkg::WORD_W-1:0] dat_re_o,
    output logic signed [bfly4_pkg::WORD_W-1:0] dat_im_o,
    input  logic signed [bfly4_pkg::WORD_W-1:0] dat_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] dat_im_i,
    input  logic                                ack_i,
    // Twiddle ROM
    output logic [bfly4_pkg::TW_AW-1:0]         tw_adr_o,
    output logic                                tw_rd_o,
    input  logic signed [bfly4_pkg::WORD_W-1:0] tw_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] tw_im_i
);
    import bfly4_pkg::*;

    bfly4_state_t state;

    bfly4_ctrl u_ctrl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .ack_i    (ack_i),
        .m_i      (m_i),
        .state_o  (state),
        .finish_o (finish_o)
    );

    bfly4_addr_gen u_addr_gen (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .state_i   (state),
        .ack_i     (ack_i),
        .m_i       (m_i),
        .fstride_i (fstride_i),
        .foutadr_i (foutadr_i),
        .adr_o     (adr_o),
        .rd_o      (rd_o),
        .wr_o      (wr_o),
        .tw_adr_o  (tw_adr_o),
        .tw_rd_o   (tw_rd_o)
    );

    bfly4_datapath u_datapath (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .state_i  (state),
        .ack_i    (ack_i),
        .inv_i    (inv_i),
        .dat_re_i (dat_re_i),
        .dat_im_i (dat_im_i),
        .tw_re_i  (tw_re_i),
        .tw_im_i  (tw_im_i),
        .dat_re_o (dat_re_o),
        .dat_im_o (dat_im_o)
    );

endmodule

/* common/bfly4_pkg.sv */
// Widths and constants of the radix-4 butterfly engine
// Sequencer state type

package bfly4_pkg;

    // One real or imaginary component, signed Q1.15
    localparam int WORD_W = 16;

    // Data memory address
    localparam int ADDR_W = 12;

    // Group count and twiddle stride
    localparam int CNT_W = 8;

    // Twiddle ROM address
    localparam int TW_AW = 8;

    // One address per complex sample
    localparam logic [ADDR_W-1:0] SAMPLE_STEP = ADDR_W'(1);

    // Loads and saves run in the odd order 2,3,1,0 and 2,0,3,1
    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        INIT  = 4'd1,
        LOAD2 = 4'd2,
        LOAD3 = 4'd3,
        LOAD1 = 4'd4,
        LOAD0 = 4'd5,
        EXEC0 = 4'd6,
        EXEC1 = 4'd7,
        EXEC2 = 4'd8,
        EXEC3 = 4'd9,
        EXEC4 = 4'd10,
        SAVE2 = 4'd11,
        SAVE0 = 4'd12,
        SAVE3 = 4'd13,
        SAVE1 = 4'd14
    } bfly4_state_t;

endpackage

/* logic/cplx_mul.sv */
// Two-stage pipelined Q1.15 complex multiplier
// Both stages freeze while hold_i is high

module cplx_mul (
    input  logic                                clk_i,
    input  logic                                hold_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] a_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] a_im_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] b_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] b_im_i,
    output logic signed [bfly4_pkg::WORD_W-1:0] x_re_o,
    output logic signed [bfly4_pkg::WORD_W-1:0] x_im_o
);
    import bfly4_pkg::*;

    // Stage 1, partial products
    logic signed [2*WORD_W-1:0] rr_q;
    logic signed [2*WORD_W-1:0] ii_q;
    logic signed [2*WORD_W-1:0] ri_q;
    logic signed [2*WORD_W-1:0] ir_q;

    // One guard bit for the sum of two products
    logic signed [2*WORD_W:0] sum_re;
    logic signed [2*WORD_W:0] sum_im;

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            rr_q <= a_re_i * b_re_i;
            ii_q <= a_im_i * b_im_i;
            ri_q <= a_re_i * b_im_i;
            ir_q <= a_im_i * b_re_i;
        end
    end

    assign sum_re = rr_q - ii_q;
    assign sum_im = ri_q + ir_q;

    // Stage 2, shift right by 15 and keep the low word
    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            x_re_o <= sum_re[2*WORD_W-2:WORD_W-1];
            x_im_o <= sum_im[2*WORD_W-2:WORD_W-1];
        end
    end

endmodule

/* sources.f */
common/bfly4_pkg.sv
logic/cplx_mul.sv
butterfly/bfly4_ctrl.sv
butterfly/bfly4_addr_gen.sv
butterfly/bfly4_datapath.sv
butterfly/bfly4_top.sv
verif/bfly4_mem_model.sv
verif/tb_bfly4.sv

/* verif/bfly4_mem_model.sv */
// Data memory with random acknowledge delay
// Twiddle ROM with registered read

module bfly4_mem_model (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [bfly4_pkg::ADDR_W-1:0]        adr_i,
    input  logic                                rd_i,
    input  logic                                wr_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] dat_re_i,
    input  logic signed [bfly4_pkg::WORD_W-1:0] dat_im_i,
    output logic signed [bfly4_pkg::WORD_W-1:0] dat_re_o,
    output logic signed [bfly4_pkg::WORD_W-1:0] dat_im_o,
    output logic                                ack_o,
    input  logic [bfly4_pkg::TW_AW-1:0]         tw_adr_i,
    input  logic                                tw_rd_i,
    output logic signed [bfly4_pkg::WORD_W-1:0] tw_re_o,
    output logic signed [bfly4_pkg::WORD_W-1:0] tw_im_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import bfly4_pkg::*;

    logic signed [WORD_W-1:0] sample_re [2**ADDR_W];
    logic signed [WORD_W-1:0] sample_im [2**ADDR_W];
    logic signed [WORD_W-1:0] tw_re [2**TW_AW];
    logic signed [WORD_W-1:0] tw_im [2**TW_AW];

    logic [15:0] lfsr_q = 16'd75;
    logic [1:0]  wait_q;
    logic [15:0] delay;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    assign ack_o    = (rd_i || wr_i) && (wait_q == 2'd0);
    assign dat_re_o = rd_i ? sample_re[adr_i] : '0;
    assign dat_im_o = rd_i ? sample_im[adr_i] : '0;

    always @(posedge clk_i) begin
        if (rst_i) begin
            wait_q <= 2'd0;
        end else if (rd_i || wr_i) begin
            if (ack_o) begin
                draw_bits(2, delay);
                wait_q <= delay[1:0];
                if (wr_i) begin
                    sample_re[adr_i] <= dat_re_i;
                    sample_im[adr_i] <= dat_im_i;
                end
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
        if (tw_rd_i) begin
            tw_re_o <= tw_re[tw_adr_i];
            tw_im_o <= tw_im[tw_adr_i];
        end
    end

endmodule

/* verif/tb_bfly4.sv */
// Testbench of the radix-4 butterfly engine
// Clock, reset, stimulus, reference model, comparison and watchdog

module tb_bfly4;
    timeunit 1ns;
    timeprecision 1ps;
    import bfly4_pkg::*;

    localparam int      CLK_NS       = 100;
    localparam int      RESET_CYC    = 10;
    localparam int      TOTAL_GROUPS = 1 + 1 + 4 + 16;
    localparam longint  WATCHDOG_NS  =
        (64 * TOTAL_GROUPS * 10 + RESET_CYC) * longint'(CLK_NS);

    logic                     clk_i = 1'b0;
    logic                     rst_i;
    logic                     start_i;
    logic [CNT_W-1:0]         m_i;
    logic [CNT_W-1:0]         fstride_i;
    logic [ADDR_W-1:0]        foutadr_i;
    logic                     inv_i;
    logic                     finish_o;
    logic [ADDR_W-1:0]        adr_o;
    logic                     rd_o;
    logic                     wr_o;
    logic signed [WORD_W-1:0] dat_re_o;
    logic signed [WORD_W-1:0] dat_im_o;
    logic signed [WORD_W-1:0] dat_re_i;
    logic signed [WORD_W-1:0] dat_im_i;
    logic                     ack_i;
    logic [TW_AW-1:0]         tw_adr_o;
    logic                     tw_rd_o;
    logic signed [WORD_W-1:0] tw_re_i;
    logic signed [WORD_W-1:0] tw_im_i;

    logic signed [WORD_W-1:0] orig_re [2**ADDR_W];
    logic signed [WORD_W-1:0] orig_im [2**ADDR_W];
    logic signed [WORD_W-1:0] exp_re [2**ADDR_W];
    logic signed [WORD_W-1:0] exp_im [2**ADDR_W];
    bit                       exp_valid [2**ADDR_W];
    bit                       written [2**ADDR_W];

    logic [15:0] lfsr_q = 16'd75;
    bit          active = 1'b0;
    int          fin_cnt = 0;
    int          wr_cnt = 0;
    int          tw_cnt = 0;
    int          err_cnt = 0;

    always #(CLK_NS / 2) clk_i = ~clk_i;

    bfly4_top dut_i (.*);

    bfly4_mem_model mem_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .adr_i    (adr_o),
        .rd_i     (rd_o),
        .wr_i     (wr_o),
        .dat_re_i (dat_re_o),
        .dat_im_i (dat_im_o),
        .dat_re_o (dat_re_i),
        .dat_im_o (dat_im_i),
        .ack_o    (ack_i),
        .tw_adr_i (tw_adr_o),
        .tw_rd_i  (tw_rd_o),
        .tw_re_o  (tw_re_i),
        .tw_im_o  (tw_im_i)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Reference model

    // Q1.15 complex product, packed as {re, im}
    function automatic logic [31:0] cmul(input logic signed [15:0] ar, ai, br, bi);
        logic signed [32:0] p_re;
        logic signed [32:0] p_im;
        p_re = 33'(ar) * 33'(br) - 33'(ai) * 33'(bi);
        p_im = 33'(ar) * 33'(bi) + 33'(ai) * 33'(br);
        cmul = {p_re[30:15], p_im[30:15]};
    endfunction

    // Twiddles of a group are fetched as tw2, tw3, tw1, each one load ahead of its operand
    function automatic int twiddle_addr(input int n, input int f);
        int j;
        int k;
        j = n / 3;
        case (n % 3)
            0:       k = 2;
            1:       k = 3;
            default: k = 1;
        endcase
        twiddle_addr = (k * j * f) % (2**TW_AW);
    endfunction

    function automatic void compute_expected(int m, int f, int base, bit inv);
        int                a;
        int                t;
        logic signed [15:0] xr [4];
        logic signed [15:0] xi [4];
        logic signed [15:0] sr [6];
        logic signed [15:0] si [6];
        logic signed [15:0] f0r;
        logic signed [15:0] f0i;
        logic [31:0]        p;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            exp_valid[i] = 1'b0;
            written[i] = 1'b0;
        end
        for (int j = 0; j < m; j++) begin
            for (int k = 0; k < 4; k++) begin
                a = (base + k * m + j) % (2**ADDR_W);
                xr[k] = mem_i.sample_re[a];
                xi[k] = mem_i.sample_im[a];
                xr[k] = xr[k] >>> 2;
                xi[k] = xi[k] >>> 2;
            end
            for (int k = 1; k < 4; k++) begin
                t = (k * j * f) % (2**TW_AW);
                p = cmul(xr[k], xi[k], mem_i.tw_re[t], mem_i.tw_im[t]);
                sr[k-1] = p[31:16];
                si[k-1] = p[15:0];
            end
            sr[5] = xr[0] - sr[1];
            si[5] = xi[0] - si[1];
            f0r = xr[0] + sr[1];
            f0i = xi[0] + si[1];
            sr[3] = sr[0] + sr[2];
            si[3] = si[0] + si[2];
            sr[4] = sr[0] - sr[2];
            si[4] = si[0] - si[2];
            for (int k = 0; k < 4; k++) begin
                a = (base + k * m + j) % (2**ADDR_W);
                exp_valid[a] = 1'b1;
                case (k)
                    0: begin
                        exp_re[a] = f0r + sr[3];
                        exp_im[a] = f0i + si[3];
                    end
                    2: begin
                        exp_re[a] = f0r - sr[3];
                        exp_im[a] = f0i - si[3];
                    end
                    // Forward X1 adds the rotated s4, inverse subtracts it
                    default: begin
                        if ((k == 1) ^ inv) begin
                            exp_re[a] = sr[5] + si[4];
                            exp_im[a] = si[5] - sr[4];
                        end else begin
                            exp_re[a] = sr[5] - si[4];
                            exp_im[a] = si[5] + sr[4];
                        end
                    end
                endcase
            end
        end
    endfunction

    //////////////////////////////
    // Bus monitor and comparison

    always @(posedge clk_i) begin
        if (!rst_i) begin
            check_value("rd_o & wr_o", 32'(rd_o & wr_o), 32'd0);
            if (!active) begin
                check_value("rd_o", 32'(rd_o), 32'd0);
                check_value("wr_o", 32'(wr_o), 32'd0);
                check_value("tw_rd_o", 32'(tw_rd_o), 32'd0);
                check_value("finish_o", 32'(finish_o), 32'd0);
            end else begin
                if (rd_o && ack_i) begin
                    check_value("adr_o read valid", 32'(exp_valid[adr_o]), 32'd1);
                end
                if (tw_rd_o) begin
                    check_value("tw_rd_o with read ack", 32'(rd_o && ack_i), 32'd1);
                    check_value("tw_adr_o", 32'(tw_adr_o),
                                32'(twiddle_addr(tw_cnt, fstride_i)));
                    tw_cnt++;
                end
                if (wr_o && ack_i) begin
                    check_value("adr_o write valid", 32'(exp_valid[adr_o]), 32'd1);
                    check_value("adr_o write count", 32'(written[adr_o]), 32'd0);
                    check_value("dat_re_o", 32'(dat_re_o), 32'(exp_re[adr_o]));
                    check_value("dat_im_o", 32'(dat_im_o), 32'(exp_im[adr_o]));
                    written[adr_o] = 1'b1;
                    wr_cnt++;
                end
                if (finish_o) begin
                    check_value("finish_o with write ack", 32'(wr_o && ack_i), 32'd1);
                    check_value("write total", 32'(wr_cnt), 32'(4 * m_i));
                    check_value("twiddle reads", 32'(tw_cnt), 32'(3 * m_i));
                    fin_cnt++;
                    active = 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus

    task automatic run_cmd(input int m, input int f, input int base, input bit inv);
        int prev;
        @(negedge clk_i);
        m_i = CNT_W'(m);
        fstride_i = CNT_W'(f);
        foutadr_i = ADDR_W'(base);
        inv_i = inv;
        compute_expected(m, f, base, inv);
        wr_cnt = 0;
        tw_cnt = 0;
        prev = fin_cnt;
        active = 1'b1;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        while (fin_cnt == prev) begin
            @(posedge clk_i);
        end
        // A second finish_o or a late access fails the idle checks of the monitor
        repeat (5) @(negedge clk_i);
    endtask

    initial begin
        logic [15:0] v;
        rst_i = 1'b1;
        start_i = 1'b0;
        m_i = '0;
        fstride_i = '0;
        foutadr_i = '0;
        inv_i = 1'b0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            draw_bits(16, v);
            orig_re[a] = v;
            draw_bits(16, v);
            orig_im[a] = v;
            mem_i.sample_re[a] = orig_re[a];
            mem_i.sample_im[a] = orig_im[a];
        end
        for (int t = 0; t < 2**TW_AW; t++) begin
            draw_bits(16, v);
            mem_i.tw_re[t] = v;
            draw_bits(16, v);
            mem_i.tw_im[t] = v;
        end
        repeat (RESET_CYC) @(negedge clk_i);
        rst_i = 1'b0;
        // Idle outputs are watched by the monitor until the first start
        repeat (8) @(negedge clk_i);

        run_cmd(1, 0, 100, 1'b0);
        for (int a = 100; a < 104; a++) begin
            mem_i.sample_re[a] = orig_re[a];
            mem_i.sample_im[a] = orig_im[a];
        end
        run_cmd(1, 0, 100, 1'b1);
        run_cmd(4, 5, 600, 1'b0);
        run_cmd(16, 3, 2000, 1'b1);

        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the engine did not finish all commands in time");
        $display("Errors found");
        $fatal(1);
    end

endmodule
